/* fe_rx.f */
+incdir+test
verilog/fe_rx_pkg.sv
verilog/rx_byte_if.sv
verilog/rx_symbol_decoder.sv
verilog/rx_sync_monitor.sv
verilog/rx_word_assembler.sv
verilog/rx_bus_regs.sv
verilog/fe_rx_core.sv
test/tb_fe_rx_core.sv

/* Bender.yml */
package:
  name: fe_rx

sources:
  - verilog/fe_rx_pkg.sv
  - verilog/rx_byte_if.sv
  - verilog/rx_symbol_decoder.sv
  - verilog/rx_sync_monitor.sv
  - verilog/rx_word_assembler.sv
  - verilog/rx_bus_regs.sv
  - verilog/fe_rx_core.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_fe_rx_core.sv

/* test/tb_fe_rx_encoder.svh */
`ifndef TB_FE_RX_ENCODER_SVH
`define TB_FE_RX_ENCODER_SVH

// 5b6b and 3b4b codes, RD- column, indexed by the input bits
localparam logic [5:0] TAB6 [32] = '{
    6'b100111, 6'b011101, 6'b101101, 6'b110001, 6'b110101, 6'b101001, 6'b011001, 6'b111000,
    6'b111001, 6'b100101, 6'b010101, 6'b110100, 6'b001101, 6'b101100, 6'b011100, 6'b010111,
    6'b011011, 6'b100011, 6'b010011, 6'b110010, 6'b001011, 6'b101010, 6'b011010, 6'b111010,
    6'b110011, 6'b100110, 6'b010110, 6'b110110, 6'b001110, 6'b101110, 6'b011110, 6'b101011};
localparam logic [3:0] TAB4 [8] = '{4'b1011, 4'b1001, 4'b0101, 4'b1100,
                                    4'b1101, 4'b1010, 4'b0110, 4'b1110};
localparam logic [3:0] KTAB4 [8] = '{4'b0100, 4'b1001, 4'b0101, 4'b0011,
                                     4'b0010, 4'b1010, 4'b0110, 4'b1000};

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x ^ (x << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
endfunction

// an unbalanced sub-block sets the sign of the running disparity
function automatic void update_disp(input int ones, input int half);
    if (ones != half) begin
        run_disp = (ones > half);
    end
endfunction

function automatic logic [9:0] encode_symbol(input logic [7:0] b, input bit k);
    logic [5:0] c6;
    logic [3:0] c4;
    c6 = k ? 6'b001111 : TAB6[b[4:0]];
    if (run_disp && (($countones(c6) != 3) || (!k && b[4:0] == 5'd7))) begin
        c6 = ~c6;
    end
    update_disp($countones(c6), 3);
    if (k) begin
        c4 = run_disp ? KTAB4[b[7:5]] : ~KTAB4[b[7:5]];
    end else begin
        c4 = TAB4[b[7:5]];
        if (run_disp && (($countones(c4) != 2) || (b[7:5] == 3'd3))) begin
            c4 = ~c4;
        end
    end
    update_disp($countones(c4), 2);
    return {c6, c4};
endfunction

task automatic send_raw(input logic [9:0] w);
    @(posedge BUS_CLK);
    symbol       <= w;
    symbol_valid <= 1'b1;
endtask

task automatic send_byte(input logic [7:0] b, input bit k);
    send_raw(encode_symbol(b, k));
endtask

// payload from the xorshift stream, complete words optionally expected
task automatic send_frame(input int n, input bit expect_out);
    logic [23:0] word;
    logic [7:0]  b;
    word = '0;
    send_byte(K28_7, 1'b1);
    for (int i = 0; i < n; i++) begin
        pay_state = xorshift32(pay_state);
        b = pay_state[7:0];
        word = {word[15:0], b};
        send_byte(b, 1'b0);
        if ((i % 3 == 2) && expect_out && (exp_q.size() < FIFO_DEPTH)) begin
            exp_q.push_back({DATA_ID, word});
            refresh_head();
        end
    end
    send_byte(K28_3, 1'b1);
    send_byte(K28_5, 1'b1);
endtask

`endif

/* test/tb_fe_rx_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fe_rx_core;
    import fe_rx_pkg::*;

    localparam logic [15:0] REG_RESET  = 16'd0;
    localparam logic [15:0] REG_STATUS = 16'd1;
    localparam logic [15:0] REG_LEVEL  = 16'd2;
    localparam logic [15:0] REG_DEC    = 16'd3;
    localparam logic [15:0] REG_DISP   = 16'd4;
    localparam logic [15:0] REG_LOST   = 16'd5;

    // rough cycle budget per phase
    localparam int PH_LOCK  = 60;
    localparam int PH_DATA  = 260;
    localparam int PH_OVFL  = 160;
    localparam int PH_ERR   = 50;
    localparam int PH_SRST  = 50;
    localparam int MAX_CYCLES = 2 * (PH_LOCK + PH_DATA + PH_OVFL + PH_ERR + PH_SRST);

    logic        BUS_CLK;
    logic        arst_n;
    logic [9:0]  symbol;
    logic        symbol_valid;
    logic        fifo_ready;
    logic        fifo_valid;
    logic [31:0] fifo_data;
    logic        rx_locked;
    logic [15:0] bus_add;
    logic [7:0]  bus_data_in;
    logic        bus_wr;
    logic        bus_rd;
    logic [7:0]  bus_data_out;

    logic [31:0] exp_q[$];
    logic [31:0] exp_head;
    int          exp_cnt;
    logic        run_disp;
    logic [31:0] pay_state;
    logic [31:0] rdy_state;
    logic        ready_rand;
    logic        chk_en;
    logic [7:0]  chk_val;
    int          data_errs;
    int          reg_errs;
    int          cycles;

    function automatic void refresh_head();
        exp_cnt  = exp_q.size();
        exp_head = (exp_q.size() != 0) ? exp_q[0] : '0;
    endfunction

    `include "tb_fe_rx_encoder.svh"

    fe_rx_core i_dut (
        .BUS_CLK      (BUS_CLK),
        .arst_n       (arst_n),
        .symbol       (symbol),
        .symbol_valid (symbol_valid),
        .fifo_valid   (fifo_valid),
        .fifo_ready   (fifo_ready),
        .fifo_data    (fifo_data),
        .rx_locked    (rx_locked),
        .bus_add      (bus_add),
        .bus_data_in  (bus_data_in),
        .bus_wr       (bus_wr),
        .bus_rd       (bus_rd),
        .bus_data_out (bus_data_out)
    );

    initial begin
        BUS_CLK = 1'b0;
        forever #50 BUS_CLK = ~BUS_CLK;
    end

    // read one register and arm the check for the next edge
    task automatic read_reg(input logic [15:0] addr, input logic [7:0] value);
        @(posedge BUS_CLK);
        symbol_valid <= 1'b0;
        bus_add      <= addr;
        bus_rd       <= 1'b1;
        chk_en       <= 1'b1;
        chk_val      <= value;
        @(posedge BUS_CLK);
        bus_rd <= 1'b0;
        chk_en <= 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge BUS_CLK);
            symbol_valid <= 1'b0;
        end
    endtask

    task automatic soft_reset();
        @(posedge BUS_CLK);
        symbol_valid <= 1'b0;
        bus_add      <= REG_RESET;
        bus_wr       <= 1'b1;
        @(posedge BUS_CLK);
        bus_wr   <= 1'b0;
        run_disp = 1'b0;
        exp_q.delete();
        refresh_head();
        idle(2);
    endtask

    always @(posedge BUS_CLK) begin
        if (ready_rand) begin
            rdy_state = xorshift32(rdy_state);
            fifo_ready <= rdy_state[3];
        end else begin
            fifo_ready <= 1'b0;
        end
    end

    always @(posedge BUS_CLK) begin
        if (arst_n && fifo_valid && fifo_ready && (exp_q.size() != 0)) begin
            void'(exp_q.pop_front());
            refresh_head();
        end
    end

    assert property (@(posedge BUS_CLK) disable iff (!arst_n)
        (fifo_valid && fifo_ready) |-> ((exp_cnt != 0) && (fifo_data == exp_head)))
        else begin
            data_errs++;
            $display("Error %0t ns: fifo word %h, expected %h (%0d queued)", $time,
                     $sampled(fifo_data), $sampled(exp_head), $sampled(exp_cnt));
        end

    assert property (@(posedge BUS_CLK) disable iff (!arst_n)
        (fifo_valid && !fifo_ready) |=> (!fifo_valid || $stable(fifo_data)))
        else begin
            data_errs++;
            $display("Error %0t ns: fifo_data changed while stalled", $time);
        end

    assert property (@(posedge BUS_CLK) disable iff (!arst_n)
        i_dut.soft_rst |=> !fifo_valid)
        else begin
            data_errs++;
            $display("Error %0t ns: fifo_valid still high after soft reset", $time);
        end

    assert property (@(posedge BUS_CLK) disable iff (!arst_n)
        chk_en |=> (bus_data_out == $past(chk_val)))
        else begin
            reg_errs++;
            $display("Error %0t ns: register read %h, expected %h", $time,
                     $sampled(bus_data_out), $past(chk_val));
        end

    // lock output follows the expected status bit 0
    assert property (@(posedge BUS_CLK) disable iff (!arst_n)
        (chk_en && (bus_add == REG_STATUS)) |=> (rx_locked == $past(chk_val[0])))
        else begin
            reg_errs++;
            $display("Error %0t ns: rx_locked %b, expected %b", $time,
                     $sampled(rx_locked), $past(chk_val[0]));
        end

    always @(posedge BUS_CLK) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("TESTS FAILED");
            $finish;
        end
    end

    initial begin
        arst_n       = 1'b0;
        symbol       = '0;
        symbol_valid = 1'b0;
        fifo_ready   = 1'b0;
        bus_add      = '0;
        bus_data_in  = '0;
        bus_wr       = 1'b0;
        bus_rd       = 1'b0;
        chk_en       = 1'b0;
        chk_val      = '0;
        ready_rand   = 1'b0;
        run_disp     = 1'b0;
        pay_state    = 32'd24612;
        rdy_state    = xorshift32(32'd24612);
        data_errs    = 0;
        reg_errs     = 0;
        cycles       = 0;
        refresh_head();
        repeat (8) @(posedge BUS_CLK);
        arst_n <= 1'b1;

        // gating before lock, then lock after the fourth comma
        // the frame closes with the first comma
        send_frame(6, 1'b0);
        repeat (2) send_byte(K28_5, 1'b1);
        read_reg(REG_STATUS, 8'h00);
        send_byte(K28_5, 1'b1);
        read_reg(REG_STATUS, 8'h01);
        repeat (5) send_byte(8'h3A, 1'b0);
        idle(4);
        read_reg(REG_LEVEL, 8'd0);

        // random frames with random back-pressure
        ready_rand <= 1'b1;
        for (int f = 0; f < 10; f++) begin
            pay_state = xorshift32(pay_state);
            send_frame(3 + int'(pay_state % 10), 1'b1);
        end
        idle(2);
        while (exp_q.size() != 0) @(posedge BUS_CLK);

        // overflow with 5 frames of 4 words against a stalled reader
        ready_rand <= 1'b0;
        idle(4);
        repeat (5) send_frame(12, 1'b1);
        idle(4);
        read_reg(REG_LEVEL, 8'd16);
        read_reg(REG_STATUS, 8'h03);
        read_reg(REG_LOST, 8'd4);
        ready_rand <= 1'b1;
        while (exp_q.size() != 0) @(posedge BUS_CLK);
        ready_rand <= 1'b0;

        // invalid code inside a frame, then a comma of the wrong disparity
        send_byte(K28_7, 1'b1);
        repeat (2) send_byte(8'h55, 1'b0);
        send_raw(run_disp ? ~10'b1111000101 : 10'b1111000101);
        // the bad symbol flips the running disparity
        update_disp(run_disp ? 2 : 4, 3);
        repeat (3) send_byte(8'h66, 1'b0);
        send_byte(K28_3, 1'b1);
        idle(4);
        read_reg(REG_DEC, 8'd1);
        read_reg(REG_LEVEL, 8'd0);
        // unbalanced block of the current sign keeps the running disparity
        send_raw(run_disp ? 10'b0011111010 : 10'b1100000101);
        idle(2);
        read_reg(REG_DISP, 8'd1);
        read_reg(REG_STATUS, 8'h00);

        // soft reset with words waiting in the fifo
        repeat (4) send_byte(K28_5, 1'b1);
        send_frame(6, 1'b1);
        idle(4);
        read_reg(REG_LEVEL, 8'd2);
        soft_reset();
        read_reg(REG_STATUS, 8'h00);
        read_reg(REG_LEVEL, 8'd0);
        read_reg(REG_DEC, 8'd0);
        read_reg(REG_DISP, 8'd0);
        read_reg(REG_LOST, 8'd0);
        idle(2);

        $display("run complete: %0d data errors, %0d register errors", data_errs, reg_errs);
        if ((data_errs == 0) && (reg_errs == 0)) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/fe_rx_core.sv */
`timescale 1ns/1ps
`default_nettype none

module fe_rx_core (
    input  wire        BUS_CLK,
    input  wire        arst_n,
    input  wire [9:0]  symbol,
    input  wire        symbol_valid,
    output wire        fifo_valid,
    input  wire        fifo_ready,
    output wire [31:0] fifo_data,
    output wire        rx_locked,
    input  wire [15:0] bus_add,
    input  wire [7:0]  bus_data_in,
    input  wire        bus_wr,
    input  wire        bus_rd,
    output wire [7:0]  bus_data_out
);
    import fe_rx_pkg::*;

    wire             soft_rst;
    wire             fifo_full;
    wire [FIFO_AW:0] fifo_level;
    wire [CNT_W-1:0] decoder_err_cnt;
    wire [CNT_W-1:0] disp_err_cnt;
    wire [CNT_W-1:0] lost_cnt;

    rx_byte_if byte_bus ();

    // decoder and monitor see the same symbol in parallel
    rx_symbol_decoder i_decoder (
        .BUS_CLK      (BUS_CLK),
        .arst_n       (arst_n),
        .soft_rst     (soft_rst),
        .symbol       (symbol),
        .symbol_valid (symbol_valid),
        .byte_out     (byte_bus.source)
    );

    rx_sync_monitor i_monitor (
        .BUS_CLK      (BUS_CLK),
        .arst_n       (arst_n),
        .soft_rst     (soft_rst),
        .symbol       (symbol),
        .symbol_valid (symbol_valid),
        .locked       (rx_locked),
        .disp_err_cnt (disp_err_cnt)
    );

    rx_word_assembler i_assembler (
        .BUS_CLK         (BUS_CLK),
        .arst_n          (arst_n),
        .soft_rst        (soft_rst),
        .byte_in         (byte_bus.sink),
        .locked          (rx_locked),
        .fifo_ready      (fifo_ready),
        .fifo_valid      (fifo_valid),
        .fifo_data       (fifo_data),
        .fifo_level      (fifo_level),
        .fifo_full       (fifo_full),
        .decoder_err_cnt (decoder_err_cnt),
        .lost_cnt        (lost_cnt)
    );

    rx_bus_regs i_regs (
        .BUS_CLK         (BUS_CLK),
        .arst_n          (arst_n),
        .bus_add         (bus_add),
        .bus_data_in     (bus_data_in),
        .bus_wr          (bus_wr),
        .bus_rd          (bus_rd),
        .bus_data_out    (bus_data_out),
        .soft_rst        (soft_rst),
        .locked          (rx_locked),
        .fifo_full       (fifo_full),
        .fifo_level      (fifo_level),
        .decoder_err_cnt (decoder_err_cnt),
        .disp_err_cnt    (disp_err_cnt),
        .lost_cnt        (lost_cnt)
    );

endmodule

`default_nettype wire

/* verilog/rx_bus_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module rx_bus_regs (
    input  wire                         BUS_CLK,
    input  wire                         arst_n,
    input  wire [15:0]                  bus_add,
    input  wire [7:0]                   bus_data_in,
    input  wire                         bus_wr,
    input  wire                         bus_rd,
    output logic [7:0]                  bus_data_out,
    output logic                        soft_rst,
    input  wire                         locked,
    input  wire                         fifo_full,
    input  wire [fe_rx_pkg::FIFO_AW:0]  fifo_level,
    input  wire [fe_rx_pkg::CNT_W-1:0]  decoder_err_cnt,
    input  wire [fe_rx_pkg::CNT_W-1:0]  disp_err_cnt,
    input  wire [fe_rx_pkg::CNT_W-1:0]  lost_cnt
);

    localparam logic [15:0] ADDR_RESET   = 16'd0;
    localparam logic [15:0] ADDR_STATUS  = 16'd1;
    localparam logic [15:0] ADDR_LEVEL   = 16'd2;
    localparam logic [15:0] ADDR_DEC_ERR = 16'd3;
    localparam logic [15:0] ADDR_DISP    = 16'd4;
    localparam logic [15:0] ADDR_LOST    = 16'd5;

    logic [7:0] rd_mux;

    always_comb begin
        case (bus_add)
            ADDR_STATUS:  rd_mux = {6'd0, fifo_full, locked};
            ADDR_LEVEL:   rd_mux = 8'(fifo_level);
            ADDR_DEC_ERR: rd_mux = 8'(decoder_err_cnt);
            ADDR_DISP:    rd_mux = 8'(disp_err_cnt);
            ADDR_LOST:    rd_mux = 8'(lost_cnt);
            default:      rd_mux = 8'd0;
        endcase
    end

    // any write to address 0 resets, the write data is ignored
    always_ff @(posedge BUS_CLK or negedge arst_n) begin
        if (!arst_n) begin
            soft_rst     <= 1'b0;
            bus_data_out <= 8'd0;
        end else begin
            soft_rst <= bus_wr && (bus_add == ADDR_RESET) && !soft_rst;
            if (bus_rd) begin
                bus_data_out <= rd_mux;
            end
        end
    end

    assert property (@(posedge BUS_CLK) disable iff (!arst_n)
        soft_rst |=> !soft_rst);

endmodule

`default_nettype wire

/* verilog/rx_word_assembler.sv */
`timescale 1ns/1ps
`default_nettype none

module rx_word_assembler (
    input  wire                         BUS_CLK,
    input  wire                         arst_n,
    input  wire                         soft_rst,
    rx_byte_if.sink                     byte_in,
    input  wire                         locked,
    input  wire                         fifo_ready,
    output logic                        fifo_valid,
    output logic [31:0]                 fifo_data,
    output logic [fe_rx_pkg::FIFO_AW:0] fifo_level,
    output logic                        fifo_full,
    output logic [fe_rx_pkg::CNT_W-1:0] decoder_err_cnt,
    output logic [fe_rx_pkg::CNT_W-1:0] lost_cnt
);
    import fe_rx_pkg::*;

    logic [23:0]        mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic               in_frame;
    logic [1:0]         byte_cnt;
    logic [15:0]        word_buf;
    logic               data_byte;
    logic               word_done;
    logic               wr_en;
    logic               rd_en;

    // payload byte inside an open frame
    assign data_byte = byte_in.valid && locked && in_frame && !byte_in.is_k
                       && !byte_in.code_err;
    assign word_done = data_byte && (byte_cnt == 2'd2);
    assign wr_en     = word_done && !fifo_full;
    assign rd_en     = fifo_valid && fifo_ready;

    assign fifo_full  = (fifo_level == (FIFO_AW + 1)'(FIFO_DEPTH));
    assign fifo_valid = (fifo_level != '0);
    assign fifo_data  = {DATA_ID, mem[rd_ptr]};

    always_ff @(posedge BUS_CLK or negedge arst_n) begin
        if (!arst_n) begin
            in_frame <= 1'b0;
            byte_cnt <= 2'd0;
        end else if (soft_rst) begin
            in_frame <= 1'b0;
            byte_cnt <= 2'd0;
        end else if (byte_in.valid) begin
            if (byte_in.code_err || !locked) begin
                in_frame <= 1'b0;
                byte_cnt <= 2'd0;
            end else if (byte_in.is_k) begin
                // SOF restarts, EOF drops a partial word, idles are skipped
                if ((byte_in.data == K28_7) || (byte_in.data == K28_3)) begin
                    in_frame <= (byte_in.data == K28_7);
                    byte_cnt <= 2'd0;
                end
            end else if (in_frame) begin
                byte_cnt <= (byte_cnt == 2'd2) ? 2'd0 : byte_cnt + 2'd1;
            end
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (data_byte) begin
            word_buf <= {word_buf[7:0], byte_in.data};
        end
        if (wr_en) begin
            mem[wr_ptr] <= {word_buf, byte_in.data};
        end
    end

    always_ff @(posedge BUS_CLK or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr          <= '0;
            rd_ptr          <= '0;
            fifo_level      <= '0;
            decoder_err_cnt <= '0;
            lost_cnt        <= '0;
        end else if (soft_rst) begin
            wr_ptr          <= '0;
            rd_ptr          <= '0;
            fifo_level      <= '0;
            decoder_err_cnt <= '0;
            lost_cnt        <= '0;
        end else begin
            wr_ptr     <= wr_ptr + FIFO_AW'(wr_en);
            rd_ptr     <= rd_ptr + FIFO_AW'(rd_en);
            fifo_level <= fifo_level + (FIFO_AW + 1)'(wr_en) - (FIFO_AW + 1)'(rd_en);
            if (byte_in.valid && byte_in.code_err && (decoder_err_cnt != '1)) begin
                decoder_err_cnt <= decoder_err_cnt + 1'b1;
            end
            // word dropped on overflow
            if (word_done && fifo_full && (lost_cnt != '1)) begin
                lost_cnt <= lost_cnt + 1'b1;
            end
        end
    end

    // level stays within the depth and agrees with the pointers
    assert property (@(posedge BUS_CLK) disable iff (!arst_n)
        (fifo_level <= (FIFO_AW + 1)'(FIFO_DEPTH))
        && (fifo_level[FIFO_AW-1:0] == wr_ptr - rd_ptr));

endmodule

`default_nettype wire

/* verilog/rx_sync_monitor.sv */
`timescale 1ns/1ps
`default_nettype none

module rx_sync_monitor (
    input  wire                         BUS_CLK,
    input  wire                         arst_n,
    input  wire                         soft_rst,
    input  wire fe_rx_pkg::sym_t        symbol,
    input  wire                         symbol_valid,
    output logic                        locked,
    output logic [fe_rx_pkg::CNT_W-1:0] disp_err_cnt
);
    import fe_rx_pkg::*;

    localparam int CC_W = $clog2(LOCK_COMMAS);

    logic [2:0]      ones6;
    logic [2:0]      ones4;
    logic            rd;
    logic            rd_mid;
    logic            rd_next;
    logic            disp_err;
    logic            is_comma;
    logic [CC_W-1:0] comma_cnt;

    assign ones6 = 3'($countones(symbol.sub.abcdei));
    assign ones4 = 3'($countones(symbol.sub.fghj));

    // K28.5 in either disparity column
    assign is_comma = (symbol.word == 10'b0011111010) || (symbol.word == 10'b1100000101);

    // rd is 1 for positive running disparity
    always_comb begin
        disp_err = ((ones6 > 3'd3) && rd) || ((ones6 < 3'd3) && !rd);
        rd_mid   = (ones6 == 3'd3) ? rd : (ones6 > 3'd3);
        if (((ones4 > 3'd2) && rd_mid) || ((ones4 < 3'd2) && !rd_mid)) begin
            disp_err = 1'b1;
        end
        rd_next = (ones4 == 3'd2) ? rd_mid : (ones4 > 3'd2);
    end

    always_ff @(posedge BUS_CLK or negedge arst_n) begin
        if (!arst_n) begin
            rd           <= 1'b0;
            locked       <= 1'b0;
            comma_cnt    <= '0;
            disp_err_cnt <= '0;
        end else if (soft_rst) begin
            rd           <= 1'b0;
            locked       <= 1'b0;
            comma_cnt    <= '0;
            disp_err_cnt <= '0;
        end else if (symbol_valid) begin
            rd <= rd_next;
            if (disp_err) begin
                locked    <= 1'b0;
                comma_cnt <= '0;
                if (disp_err_cnt != '1) begin
                    disp_err_cnt <= disp_err_cnt + 1'b1;
                end
            end else if (!locked) begin
                if (!is_comma) begin
                    comma_cnt <= '0;
                end else if (comma_cnt == CC_W'(LOCK_COMMAS - 1)) begin
                    locked <= 1'b1;
                end else begin
                    comma_cnt <= comma_cnt + 1'b1;
                end
            end
        end
    end

    assert property (@(posedge BUS_CLK) disable iff (!arst_n)
        $rose(locked) |-> $past(symbol_valid && is_comma));

endmodule

`default_nettype wire

/* verilog/rx_symbol_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module rx_symbol_decoder (
    input  wire               BUS_CLK,
    input  wire               arst_n,
    input  wire               soft_rst,
    input  wire fe_rx_pkg::sym_t symbol,
    input  wire               symbol_valid,
    rx_byte_if.source         byte_out
);

    logic [4:0] dec5;
    logic [2:0] dec3;
    logic [3:0] k_fghj;
    logic       k28;
    logic       err6;
    logic       err4;
    logic       bad_weight;

    assign k28 = (symbol.sub.abcdei == 6'b001111) || (symbol.sub.abcdei == 6'b110000);

    // fold the RD+ form of a K28 tail onto its RD- form
    assign k_fghj = symbol.sub.abcdei[0] ? symbol.sub.fghj : ~symbol.sub.fghj;

    // a legal symbol carries four to six ones
    assign bad_weight = ($countones(symbol.word) < 4) || ($countones(symbol.word) > 6);

    // 5b6b, both disparity columns
    always_comb begin
        err6 = 1'b0;
        case (symbol.sub.abcdei)
            6'b100111, 6'b011000: dec5 = 5'd0;
            6'b011101, 6'b100010: dec5 = 5'd1;
            6'b101101, 6'b010010: dec5 = 5'd2;
            6'b110001:            dec5 = 5'd3;
            6'b110101, 6'b001010: dec5 = 5'd4;
            6'b101001:            dec5 = 5'd5;
            6'b011001:            dec5 = 5'd6;
            6'b111000, 6'b000111: dec5 = 5'd7;
            6'b111001, 6'b000110: dec5 = 5'd8;
            6'b100101:            dec5 = 5'd9;
            6'b010101:            dec5 = 5'd10;
            6'b110100:            dec5 = 5'd11;
            6'b001101:            dec5 = 5'd12;
            6'b101100:            dec5 = 5'd13;
            6'b011100:            dec5 = 5'd14;
            6'b010111, 6'b101000: dec5 = 5'd15;
            6'b011011, 6'b100100: dec5 = 5'd16;
            6'b100011:            dec5 = 5'd17;
            6'b010011:            dec5 = 5'd18;
            6'b110010:            dec5 = 5'd19;
            6'b001011:            dec5 = 5'd20;
            6'b101010:            dec5 = 5'd21;
            6'b011010:            dec5 = 5'd22;
            6'b111010, 6'b000101: dec5 = 5'd23;
            6'b110011, 6'b001100: dec5 = 5'd24;
            6'b100110:            dec5 = 5'd25;
            6'b010110:            dec5 = 5'd26;
            6'b110110, 6'b001001: dec5 = 5'd27;
            6'b001110:            dec5 = 5'd28;
            6'b101110, 6'b010001: dec5 = 5'd29;
            6'b011110, 6'b100001: dec5 = 5'd30;
            6'b101011, 6'b010100: dec5 = 5'd31;
            default: begin
                dec5 = 5'd28;
                err6 = !k28;
            end
        endcase
    end

    // 3b4b, K28 tails use their own table
    always_comb begin
        err4 = 1'b0;
        dec3 = 3'd0;
        if (k28) begin
            case (k_fghj)
                4'b0100: dec3 = 3'd0;
                4'b1001: dec3 = 3'd1;
                4'b0101: dec3 = 3'd2;
                4'b0011: dec3 = 3'd3;
                4'b0010: dec3 = 3'd4;
                4'b1010: dec3 = 3'd5;
                4'b0110: dec3 = 3'd6;
                4'b1000: dec3 = 3'd7;
                default: err4 = 1'b1;
            endcase
        end else begin
            case (symbol.sub.fghj)
                4'b1011, 4'b0100: dec3 = 3'd0;
                4'b1001:          dec3 = 3'd1;
                4'b0101:          dec3 = 3'd2;
                4'b1100, 4'b0011: dec3 = 3'd3;
                4'b1101, 4'b0010: dec3 = 3'd4;
                4'b1010:          dec3 = 3'd5;
                4'b0110:          dec3 = 3'd6;
                4'b1110, 4'b0001: dec3 = 3'd7;
                4'b0111, 4'b1000: dec3 = 3'd7;
                default:          err4 = 1'b1;
            endcase
        end
    end

    always_ff @(posedge BUS_CLK or negedge arst_n) begin
        if (!arst_n) begin
            byte_out.valid    <= 1'b0;
            byte_out.code_err <= 1'b0;
        end else if (soft_rst) begin
            byte_out.valid    <= 1'b0;
            byte_out.code_err <= 1'b0;
        end else begin
            byte_out.valid    <= symbol_valid;
            byte_out.code_err <= symbol_valid && (err6 || err4 || bad_weight);
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (symbol_valid) begin
            byte_out.data <= {dec3, dec5};
            byte_out.is_k <= k28;
        end
    end

    assert property (@(posedge BUS_CLK) disable iff (!arst_n)
        byte_out.code_err |-> byte_out.valid);

endmodule

`default_nettype wire

/* verilog/rx_byte_if.sv */
`timescale 1ns/1ps
`default_nettype none

// decoded byte stream, one byte per valid cycle, no back-pressure
interface rx_byte_if;
    logic       valid;
    logic [7:0] data;
    logic       is_k;
    logic       code_err;

    modport source (output valid, output data, output is_k, output code_err);

    modport sink (input valid, input data, input is_k, input code_err);

endinterface

`default_nettype wire

/* verilog/fe_rx_pkg.sv */
`default_nettype none

package fe_rx_pkg;

    // one 10b symbol, bit 9 is "a", the first bit on the line
    typedef union packed {
        logic [9:0] word;
        struct packed {
            logic [5:0] abcdei;
            logic [3:0] fghj;
        } sub;
    } sym_t;

    // control characters, as decoded bytes
    localparam logic [7:0] K28_5 = 8'hBC;
    localparam logic [7:0] K28_7 = 8'hFC;
    localparam logic [7:0] K28_3 = 8'h7C;

    // header in front of every stored word
    localparam logic [7:0] DATA_ID = 8'hE5;

    // output fifo sizing
    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_AW    = 4;

    // consecutive commas before the link counts as locked
    localparam int LOCK_COMMAS = 4;

    localparam int CNT_W = 8;

endpackage

`default_nettype wire
